// ==== common/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Base opcodes handled by this stage
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        CLASS_ALU,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_BRANCH,
        CLASS_LUI,
        CLASS_AUIPC,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_ILLEGAL
    } instr_class_e;

    typedef enum logic [1:0] {
        E2F_IDLE,
        E2F_BRANCH_TAKEN,
        E2F_EXC_START
    } e2f_cmd_e;

    typedef enum logic [1:0] {
        DCMD_NONE,
        DCMD_LOAD,
        DCMD_STORE
    } dcache_cmd_e;

    typedef enum logic [2:0] {
        DRSP_NONE,
        DRSP_DONE,
        DRSP_MISALIGNED,
        DRSP_ACCESS_FAULT,
        DRSP_PAGE_FAULT
    } dcache_resp_e;

    typedef enum logic [4:0] {
        EXC_ILLEGAL_INSTR    = 5'd2,
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_LOAD_ACCESS      = 5'd5,
        EXC_STORE_MISALIGNED = 5'd6,
        EXC_STORE_ACCESS     = 5'd7,
        EXC_LOAD_PAGE        = 5'd13,
        EXC_STORE_PAGE       = 5'd15
    } exc_cause_e;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } f2e_t;

    typedef struct packed {
        instr_class_e cls;
        logic         op_imm;  // ALU operand b is the immediate
        logic [2:0]   funct3;
        logic [6:0]   funct7;
        reg_addr_t    rd;
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        word_t        simm12;
        word_t        store_offset;
        word_t        branch_offset;
        word_t        jal_offset;
        word_t        upper_imm;
    } decoded_t;

    typedef struct packed {
        logic     ready;
        e2f_cmd_e cmd;
        word_t    target;
    } e2f_t;

    typedef struct packed {
        dcache_cmd_e cmd;
        word_t       address;
        logic [2:0]  load_type;
        logic [1:0]  store_type;
        word_t       store_data;
    } dcache_req_t;

    typedef struct packed {
        dcache_resp_e response;
        word_t        load_data;
    } dcache_rsp_t;

    typedef struct packed {
        reg_addr_t addr;
        word_t     wdata;
        logic      write;
    } rd_wb_t;

    typedef struct packed {
        logic       start;
        exc_cause_e cause;
        word_t      epc;
    } exc_t;

endpackage

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import exec_pkg::*; (
    input  f2e_t     f2e,
    output decoded_t dec
);

    word_t   instr;
    opcode_e opcode;
    logic    sign;

    assign instr  = f2e.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign sign   = instr[31];

    always_comb begin
        dec.funct3 = instr[14:12];
        dec.funct7 = instr[31:25];
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.op_imm = (opcode == OPC_OP_IMM);

        // Immediate formats, all sign extended except U
        dec.simm12        = {{20{sign}}, instr[31:20]};
        dec.store_offset  = {{20{sign}}, instr[31:25], instr[11:7]};
        dec.branch_offset = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        dec.jal_offset    = {{12{sign}}, instr[19:12], instr[20], instr[30:25],
                             instr[24:21], 1'b0};
        dec.upper_imm     = {instr[31:12], 12'h000};

        case (opcode)
            OPC_OP: begin
                // M extension not supported
                if (instr[31:25] == 7'b0000001)
                    dec.cls = CLASS_ILLEGAL;
                else
                    dec.cls = CLASS_ALU;
            end
            OPC_OP_IMM: dec.cls = CLASS_ALU;
            OPC_LUI:    dec.cls = CLASS_LUI;
            OPC_AUIPC:  dec.cls = CLASS_AUIPC;
            OPC_JAL:    dec.cls = CLASS_JAL;
            OPC_JALR: begin
                if (instr[14:12] != 3'b000)
                    dec.cls = CLASS_ILLEGAL;
                else
                    dec.cls = CLASS_JALR;
            end
            OPC_BRANCH: dec.cls = CLASS_BRANCH;
            OPC_LOAD:   dec.cls = CLASS_LOAD;
            OPC_STORE: begin
                if (instr[14])
                    dec.cls = CLASS_ILLEGAL;
                else
                    dec.cls = CLASS_STORE;
            end
            default:    dec.cls = CLASS_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import exec_pkg::*; (
    input  decoded_t dec,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output word_t    result,
    output logic     illegal
);

    word_t      op_b;
    logic [4:0] shamt;
    logic       f7_zero;
    logic       f7_alt;
    logic       bad_funct;

    assign op_b    = dec.op_imm ? dec.simm12 : rs2_data;
    assign shamt   = dec.op_imm ? dec.rs2 : rs2_data[4:0];
    assign f7_zero = (dec.funct7 == 7'b0000000);
    assign f7_alt  = (dec.funct7 == 7'b0100000);

    always_comb begin
        case (dec.funct3)
            3'b000: begin
                if (!dec.op_imm && f7_alt)
                    result = rs1_data - op_b;
                else
                    result = rs1_data + op_b;
            end
            3'b001: result = rs1_data << shamt;
            3'b010: result = {31'b0, $signed(rs1_data) < $signed(op_b)};
            3'b011: result = {31'b0, rs1_data < op_b};
            3'b100: result = rs1_data ^ op_b;
            3'b101: begin
                if (f7_alt)
                    result = $signed(rs1_data) >>> shamt;
                else
                    result = rs1_data >> shamt;
            end
            3'b110: result = rs1_data | op_b;
            default: result = rs1_data & op_b;
        endcase
    end

    // Only shifts carry funct7 bits in the immediate form
    always_comb begin
        if (dec.op_imm)
            bad_funct = ((dec.funct3 == 3'b001) && !f7_zero) ||
                        ((dec.funct3 == 3'b101) && !(f7_zero || f7_alt));
        else
            bad_funct = !(f7_zero || f7_alt) ||
                        (f7_alt && (dec.funct3 != 3'b000) && (dec.funct3 != 3'b101));
    end

    assign illegal = (dec.cls == CLASS_ALU) && bad_funct;

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit import exec_pkg::*; (
    input  decoded_t dec,
    input  word_t    pc,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output logic     taken,
    output word_t    target,
    output logic     illegal
);

    logic  cond;
    logic  bad_funct3;
    word_t jalr_sum;

    assign jalr_sum = rs1_data + dec.simm12;

    always_comb begin
        bad_funct3 = 1'b0;
        case (dec.funct3)
            3'b000: cond = (rs1_data == rs2_data);
            3'b001: cond = (rs1_data != rs2_data);
            3'b100: cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101: cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110: cond = (rs1_data < rs2_data);
            3'b111: cond = (rs1_data >= rs2_data);
            default: begin
                cond       = 1'b0;
                bad_funct3 = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (dec.cls)
            CLASS_JAL: begin
                taken  = 1'b1;
                target = pc + dec.jal_offset;
            end
            CLASS_JALR: begin
                taken  = 1'b1;
                target = {jalr_sum[31:1], 1'b0};
            end
            CLASS_BRANCH: begin
                taken  = cond;
                target = pc + dec.branch_offset;
            end
            default: begin
                taken  = 1'b0;
                target = pc + dec.branch_offset;
            end
        endcase
    end

    assign illegal = (dec.cls == CLASS_BRANCH) && bad_funct3;

endmodule

`default_nettype wire

// ==== mem_access/mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cache_reset_done,
    input  decoded_t    dec,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  dcache_rsp_t rsp,
    output dcache_req_t req,
    output logic        done,
    output logic        fault,
    output exc_cause_e  fault_cause
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   is_load;
    logic   active;
    logic   rsp_error;

    assign is_load   = (dec.cls == CLASS_LOAD);
    assign active    = cache_reset_done && (is_load || dec.cls == CLASS_STORE);
    assign rsp_error = (rsp.response == DRSP_MISALIGNED) ||
                       (rsp.response == DRSP_ACCESS_FAULT) ||
                       (rsp.response == DRSP_PAGE_FAULT);

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    always_comb begin
        req.address    = is_load ? rs1_data + dec.simm12 : rs1_data + dec.store_offset;
        req.load_type  = dec.funct3;
        req.store_type = dec.funct3[1:0];
        req.store_data = rs2_data;
        req.cmd        = DCMD_NONE;
        done           = 1'b0;
        fault          = 1'b0;
        state_nxt      = ST_IDLE;

        if (active) begin
            req.cmd   = is_load ? DCMD_LOAD : DCMD_STORE;
            state_nxt = ST_WAIT;
            // Response in the issue cycle belongs to nobody
            if (state == ST_WAIT && (rsp.response == DRSP_DONE || rsp_error)) begin
                req.cmd   = DCMD_NONE;
                done      = 1'b1;
                fault     = rsp_error;
                state_nxt = ST_IDLE;
            end
        end
    end

    always_comb begin
        case (rsp.response)
            DRSP_MISALIGNED:
                fault_cause = is_load ? EXC_LOAD_MISALIGNED : EXC_STORE_MISALIGNED;
            DRSP_PAGE_FAULT:
                fault_cause = is_load ? EXC_LOAD_PAGE : EXC_STORE_PAGE;
            default:
                fault_cause = is_load ? EXC_LOAD_ACCESS : EXC_STORE_ACCESS;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/exec_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_control import exec_pkg::*; (
    input  logic       cache_reset_done,
    input  f2e_t       f2e,
    input  decoded_t   dec,
    input  word_t      alu_result,
    input  logic       alu_illegal,
    input  logic       br_taken,
    input  word_t      br_target,
    input  logic       br_illegal,
    input  logic       mem_done,
    input  logic       mem_fault,
    input  exc_cause_e mem_fault_cause,
    input  word_t      load_data,
    output e2f_t       e2f,
    output rd_wb_t     rd_wb,
    output exc_t       exc
);

    word_t pc_plus_4;
    logic  illegal;
    logic  write_en;

    assign pc_plus_4 = f2e.pc + 32'd4;

    // Writeback value
    always_comb begin
        case (dec.cls)
            CLASS_LUI:   rd_wb.wdata = dec.upper_imm;
            CLASS_AUIPC: rd_wb.wdata = f2e.pc + dec.upper_imm;
            CLASS_JAL,
            CLASS_JALR:  rd_wb.wdata = pc_plus_4;
            CLASS_LOAD:  rd_wb.wdata = load_data;
            default:     rd_wb.wdata = alu_result;
        endcase
    end

    always_comb begin
        e2f.ready  = 1'b1;
        e2f.cmd    = E2F_IDLE;
        e2f.target = br_target;
        exc.start  = 1'b0;
        exc.cause  = EXC_ILLEGAL_INSTR;
        exc.epc    = f2e.pc;
        illegal    = 1'b0;
        write_en   = 1'b0;

        if (!cache_reset_done) begin
            e2f.ready = 1'b0;
        end else begin
            case (dec.cls)
                CLASS_ALU: begin
                    illegal  = alu_illegal;
                    write_en = 1'b1;
                end
                CLASS_JAL,
                CLASS_JALR: begin
                    e2f.cmd  = E2F_BRANCH_TAKEN;
                    write_en = 1'b1;
                end
                CLASS_BRANCH: begin
                    illegal = br_illegal;
                    if (br_taken)
                        e2f.cmd = E2F_BRANCH_TAKEN;
                end
                CLASS_LUI,
                CLASS_AUIPC: write_en = 1'b1;
                CLASS_LOAD: begin
                    e2f.ready = mem_done;
                    write_en  = mem_done && !mem_fault;
                end
                CLASS_STORE: e2f.ready = mem_done;
                default: illegal = 1'b1;
            endcase

            if (illegal) begin
                e2f.cmd   = E2F_EXC_START;
                exc.start = 1'b1;
                write_en  = 1'b0;
            end else if (mem_fault) begin
                e2f.cmd   = E2F_EXC_START;
                exc.start = 1'b1;
                exc.cause = mem_fault_cause;
            end
        end
    end

    // x0 is hardwired to zero
    assign rd_wb.addr  = dec.rd;
    assign rd_wb.write = write_en && (dec.rd != 5'd0);

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cache_reset_done,
    input  f2e_t        f2e,
    output e2f_t        e2f,
    output reg_addr_t   rs1_addr,
    output reg_addr_t   rs2_addr,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    output rd_wb_t      rd_wb,
    output exc_t        exc,
    output dcache_req_t dreq,
    input  dcache_rsp_t drsp
);

    decoded_t   dec;
    word_t      alu_result;
    logic       alu_illegal;
    logic       br_taken;
    word_t      br_target;
    logic       br_illegal;
    logic       mem_done;
    logic       mem_fault;
    exc_cause_e mem_fault_cause;

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    instr_decoder instr_decoder_i (
        .f2e (f2e),
        .dec (dec)
    );

    alu alu_i (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result),
        .illegal  (alu_illegal)
    );

    branch_unit branch_unit_i (
        .dec      (dec),
        .pc       (f2e.pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .taken    (br_taken),
        .target   (br_target),
        .illegal  (br_illegal)
    );

    mem_access mem_access_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .cache_reset_done (cache_reset_done),
        .dec              (dec),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .rsp              (drsp),
        .req              (dreq),
        .done             (mem_done),
        .fault            (mem_fault),
        .fault_cause      (mem_fault_cause)
    );

    exec_control exec_control_i (
        .cache_reset_done (cache_reset_done),
        .f2e              (f2e),
        .dec              (dec),
        .alu_result       (alu_result),
        .alu_illegal      (alu_illegal),
        .br_taken         (br_taken),
        .br_target        (br_target),
        .br_illegal       (br_illegal),
        .mem_done         (mem_done),
        .mem_fault        (mem_fault),
        .mem_fault_cause  (mem_fault_cause),
        .load_data        (drsp.load_data),
        .e2f              (e2f),
        .rd_wb            (rd_wb),
        .exc              (exc)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset low for the first five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Expected stage response to one instruction
typedef struct packed {
    logic       write;
    word_t      wdata;
    e2f_cmd_e   cmd;
    word_t      target;
    logic       exc;
    exc_cause_e cause;
} expect_t;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic word_t rand_bits(input int n);
    word_t r;
    int    i;
    r = '0;
    for (i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

function automatic word_t imm_i(input word_t ins);
    return {{20{ins[31]}}, ins[31:20]};
endfunction

function automatic word_t imm_s(input word_t ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
endfunction

function automatic word_t imm_b(input word_t ins);
    return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
endfunction

function automatic word_t imm_j(input word_t ins);
    return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
endfunction

function automatic word_t mem_address(input word_t ins, input word_t a);
    if (ins[6:0] == 7'b0000011)
        return a + imm_i(ins);
    return a + imm_s(ins);
endfunction

function automatic exc_cause_e fault_cause_for(input logic is_load, input dcache_resp_e kind);
    case (kind)
        DRSP_MISALIGNED:   return is_load ? EXC_LOAD_MISALIGNED : EXC_STORE_MISALIGNED;
        DRSP_ACCESS_FAULT: return is_load ? EXC_LOAD_ACCESS : EXC_STORE_ACCESS;
        default:           return is_load ? EXC_LOAD_PAGE : EXC_STORE_PAGE;
    endcase
endfunction

// Non-memory instructions
function automatic expect_t model_exec(input word_t ins, input word_t pc,
                                       input word_t a, input word_t b);
    expect_t    e;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       imm;
    logic       bad;
    logic       cond;
    word_t      opb;
    logic [4:0] sh;

    f3      = ins[14:12];
    f7      = ins[31:25];
    imm     = (ins[6:0] == 7'b0010011);
    opb     = imm ? imm_i(ins) : b;
    sh      = opb[4:0];
    bad     = 1'b0;
    cond    = 1'b0;
    e       = '0;
    e.cmd   = E2F_IDLE;
    e.cause = EXC_ILLEGAL_INSTR;

    case (ins[6:0])
        7'b0110011, 7'b0010011: begin
            e.write = 1'b1;
            case (f3)
                3'b000: e.wdata = (!imm && f7 == 7'h20) ? a - opb : a + opb;
                3'b001: e.wdata = a << sh;
                3'b010: e.wdata = ($signed(a) < $signed(opb)) ? 1 : 0;
                3'b011: e.wdata = (a < opb) ? 1 : 0;
                3'b100: e.wdata = a ^ opb;
                3'b101: begin
                    if (f7 == 7'h20)
                        e.wdata = $signed(a) >>> sh;
                    else
                        e.wdata = a >> sh;
                end
                3'b110: e.wdata = a | opb;
                default: e.wdata = a & opb;
            endcase
            if (imm)
                bad = (f3 == 3'b001 && f7 != 7'h00) ||
                      (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
            else
                bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
        end
        7'b0110111: begin
            e.write = 1'b1;
            e.wdata = {ins[31:12], 12'b0};
        end
        7'b0010111: begin
            e.write = 1'b1;
            e.wdata = pc + {ins[31:12], 12'b0};
        end
        7'b1101111: begin
            e.write  = 1'b1;
            e.wdata  = pc + 4;
            e.cmd    = E2F_BRANCH_TAKEN;
            e.target = pc + imm_j(ins);
        end
        7'b1100111: begin
            bad      = (f3 != 3'b000);
            e.write  = 1'b1;
            e.wdata  = pc + 4;
            e.cmd    = E2F_BRANCH_TAKEN;
            e.target = (a + imm_i(ins)) & 32'hffff_fffe;
        end
        7'b1100011: begin
            case (f3)
                3'b000: cond = (a == b);
                3'b001: cond = (a != b);
                3'b100: cond = ($signed(a) < $signed(b));
                3'b101: cond = ($signed(a) >= $signed(b));
                3'b110: cond = (a < b);
                3'b111: cond = (a >= b);
                default: bad = 1'b1;
            endcase
            if (cond) begin
                e.cmd    = E2F_BRANCH_TAKEN;
                e.target = pc + imm_b(ins);
            end
        end
        default: bad = 1'b1;
    endcase

    if (bad) begin
        e.write = 1'b0;
        e.cmd   = E2F_EXC_START;
        e.exc   = 1'b1;
    end
    if (ins[11:7] == 5'd0)
        e.write = 1'b0;
    return e;
endfunction

`endif

// ==== test/execute_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb import exec_pkg::*; ;

    localparam logic [31:0] lfsr_seed = 32'h03499f8d;
    localparam int timeout_cycles = 50;
    localparam word_t nop = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    logic        cache_reset_done;
    f2e_t        f2e;
    e2f_t        e2f;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    word_t       rs1_data;
    word_t       rs2_data;
    rd_wb_t      rd_wb;
    exc_t        exc;
    dcache_req_t dreq;
    dcache_rsp_t drsp;

    logic [31:0]  lfsr_state;
    word_t        regs [32];
    int           check_count;
    int           error_count;
    int           checks_base;
    int           errors_base;
    int           rsp_delay;
    int           rsp_wait;
    dcache_resp_e rsp_kind;
    word_t        rsp_data;
    dcache_cmd_e  cmd_seen;
    dcache_req_t  exp_req;
    logic         hold_check;

    `include "tb_model.svh"

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    tb_clock tb_clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    execute_stage execute_stage_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .cache_reset_done (cache_reset_done),
        .f2e              (f2e),
        .e2f              (e2f),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .rd_wb            (rd_wb),
        .exc              (exc),
        .dreq             (dreq),
        .drsp             (drsp)
    );

    // Cache model, one-cycle response after rsp_delay cycles of command
    always @(posedge clk) begin
        cmd_seen = dreq.cmd;
        #1;
        if (drsp.response != DRSP_NONE) begin
            drsp.response = DRSP_NONE;
        end else if (cmd_seen != DCMD_NONE) begin
            rsp_wait = rsp_wait + 1;
            if (rsp_wait >= rsp_delay) begin
                drsp.response  = rsp_kind;
                drsp.load_data = rsp_data;
                rsp_wait       = 0;
            end
        end else begin
            rsp_wait = 0;
        end
    end

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_request();
        compare_word("dreq cmd", dreq.cmd, exp_req.cmd);
        compare_word("dreq address", dreq.address, exp_req.address);
        compare_word("dreq types", {dreq.load_type, dreq.store_type},
                     {exp_req.load_type, exp_req.store_type});
        compare_word("dreq store data", dreq.store_data, exp_req.store_data);
    endtask

    task automatic wait_ready(output int lat);
        int n;
        n = 0;
        @(negedge clk);
        while (!e2f.ready && n < timeout_cycles) begin
            if (hold_check)
                check_request();
            compare_word("rd write while busy", rd_wb.write, 0);
            compare_word("exc start while busy", exc.start, 0);
            @(negedge clk);
            n++;
        end
        if (!e2f.ready) begin
            $display("Timeout: ready stayed low for %0d cycles at pc %h",
                     timeout_cycles, f2e.pc);
            $display("** FAIL **");
            $finish;
        end
        lat = n;
    endtask

    task automatic present(input word_t ins, input logic same);
        word_t a;
        word_t b;
        word_t pc;
        @(posedge clk);
        #1;
        a = rand_bits(32);
        b = a;
        if (!same)
            b = rand_bits(32);
        if (ins[19:15] != 5'd0)
            regs[ins[19:15]] = a;
        if (ins[24:20] != 5'd0)
            regs[ins[24:20]] = b;
        pc = rand_bits(30);
        f2e.instr = ins;
        f2e.pc    = {pc[29:0], 2'b00};
    endtask

    task automatic run_comb(input word_t ins, input logic same);
        expect_t e;
        int      lat;
        present(ins, same);
        e = model_exec(ins, f2e.pc, regs[ins[19:15]], regs[ins[24:20]]);
        hold_check = 1'b0;
        wait_ready(lat);
        compare_word("latency", lat, 0);
        compare_word("e2f cmd", e2f.cmd, e.cmd);
        if (e.cmd == E2F_BRANCH_TAKEN)
            compare_word("e2f target", e2f.target, e.target);
        compare_word("rd write", rd_wb.write, e.write);
        if (e.write) begin
            compare_word("rd addr", rd_wb.addr, ins[11:7]);
            compare_word("rd data", rd_wb.wdata, e.wdata);
        end
        compare_word("exc start", exc.start, e.exc);
        if (e.exc) begin
            compare_word("exc cause", exc.cause, e.cause);
            compare_word("exc epc", exc.epc, f2e.pc);
        end
        compare_word("dreq cmd", dreq.cmd, DCMD_NONE);
    endtask

    task automatic run_mem(input word_t ins, input dcache_resp_e kind);
        logic is_load;
        int   lat;
        present(ins, 1'b0);
        is_load   = (ins[6:0] == 7'b0000011);
        rsp_delay = 1 + rand_bits(2);
        rsp_kind  = kind;
        rsp_data  = rand_bits(32);
        exp_req.cmd        = is_load ? DCMD_LOAD : DCMD_STORE;
        exp_req.address    = mem_address(ins, regs[ins[19:15]]);
        exp_req.load_type  = ins[14:12];
        exp_req.store_type = ins[13:12];
        exp_req.store_data = regs[ins[24:20]];
        hold_check = 1'b1;
        wait_ready(lat);
        hold_check = 1'b0;
        compare_word("memory latency", lat, rsp_delay);
        compare_word("dreq cmd at completion", dreq.cmd, DCMD_NONE);
        if (kind == DRSP_DONE) begin
            compare_word("e2f cmd", e2f.cmd, E2F_IDLE);
            compare_word("exc start", exc.start, 0);
            compare_word("rd write", rd_wb.write, is_load && ins[11:7] != 5'd0);
            if (is_load && ins[11:7] != 5'd0) begin
                compare_word("rd addr", rd_wb.addr, ins[11:7]);
                compare_word("load data", rd_wb.wdata, rsp_data);
            end
        end else begin
            compare_word("e2f cmd", e2f.cmd, E2F_EXC_START);
            compare_word("exc start", exc.start, 1);
            compare_word("exc cause", exc.cause, fault_cause_for(is_load, kind));
            compare_word("exc epc", exc.epc, f2e.pc);
            compare_word("rd write", rd_wb.write, 0);
        end
    endtask

    function automatic word_t gen_alu();
        word_t ins;
        ins = rand_bits(32);
        ins[6:0] = rand_bits(1) ? OPC_OP : OPC_OP_IMM;
        // Register form and shifts take funct7 seriously
        if (ins[6:0] == OPC_OP || ins[13:12] == 2'b01) begin
            case (rand_bits(2))
                2'd0, 2'd1: ins[31:25] = 7'h00;
                2'd2:       ins[31:25] = 7'h20;
                default:    ;
            endcase
        end
        return ins;
    endfunction

    function automatic word_t gen_upper_jump();
        word_t ins;
        ins = rand_bits(32);
        case (rand_bits(2))
            2'd0: ins[6:0] = OPC_LUI;
            2'd1: ins[6:0] = OPC_AUIPC;
            2'd2: ins[6:0] = OPC_JAL;
            default: begin
                ins[6:0] = OPC_JALR;
                // Mostly legal, sometimes a bad funct3
                if (rand_bits(1))
                    ins[14:12] = 3'b000;
            end
        endcase
        return ins;
    endfunction

    function automatic word_t gen_branch();
        word_t ins;
        ins = rand_bits(32);
        ins[6:0] = OPC_BRANCH;
        return ins;
    endfunction

    function automatic word_t gen_mem(input logic store);
        word_t ins;
        ins = rand_bits(32);
        ins[6:0] = store ? OPC_STORE : OPC_LOAD;
        if (store)
            ins[14] = 1'b0;
        return ins;
    endfunction

    function automatic word_t gen_illegal();
        word_t ins;
        ins = rand_bits(32);
        case (rand_bits(2))
            2'd0: ins[6:0] = 7'b1110011;
            2'd1: begin
                ins[6:0]   = OPC_OP;
                ins[31:25] = 7'h01;
            end
            2'd2: ins[6:0] = 7'b0001111;
            default: ins[6:0] = 7'b0001011;
        endcase
        return ins;
    endfunction

    task automatic report_test(input string name);
        $display("%-22s %6d checks %4d errors", name,
                 check_count - checks_base, error_count - errors_base);
        checks_base = check_count;
        errors_base = error_count;
    endtask

    initial begin
        int           i;
        int           n;
        word_t        ins;
        dcache_resp_e kind;

        lfsr_state       = lfsr_seed;
        check_count      = 0;
        error_count      = 0;
        checks_base      = 0;
        errors_base      = 0;
        cache_reset_done = 1'b0;
        f2e.instr        = nop;
        f2e.pc           = '0;
        drsp.response    = DRSP_NONE;
        drsp.load_data   = '0;
        rsp_delay        = 1;
        rsp_wait         = 0;
        rsp_kind         = DRSP_DONE;
        rsp_data         = '0;
        hold_check       = 1'b0;
        exp_req          = '0;
        regs[0]          = '0;
        for (i = 1; i < 32; i++)
            regs[i] = rand_bits(32);

        @(negedge clk);
        compare_word("rd write in reset", rd_wb.write, 0);
        compare_word("exc start in reset", exc.start, 0);
        compare_word("dreq cmd in reset", dreq.cmd, DCMD_NONE);
        compare_word("e2f cmd in reset", e2f.cmd, E2F_IDLE);
        n = 0;
        while (!rst_n && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            $display("Reset was never released");
            $display("** FAIL **");
            $finish;
        end

        // Cache still in reset, nothing may complete
        for (i = 0; i < 20; i++) begin
            case (rand_bits(2))
                2'd0: ins = gen_alu();
                2'd1: ins = gen_mem(1'b0);
                2'd2: ins = gen_mem(1'b1);
                default: ins = gen_illegal();
            endcase
            present(ins, 1'b0);
            @(negedge clk);
            compare_word("ready in cache reset", e2f.ready, 0);
            compare_word("dreq cmd in cache reset", dreq.cmd, DCMD_NONE);
            compare_word("rd write in cache reset", rd_wb.write, 0);
            compare_word("exc start in cache reset", exc.start, 0);
        end
        @(posedge clk);
        #1;
        f2e.instr        = nop;
        cache_reset_done = 1'b1;
        report_test("reset and cache reset");

        for (i = 0; i < 300; i++)
            run_comb(gen_alu(), 1'b0);
        report_test("alu");

        for (i = 0; i < 150; i++)
            run_comb(gen_upper_jump(), 1'b0);
        report_test("upper and jumps");

        for (i = 0; i < 200; i++) begin
            ins = gen_branch();
            run_comb(ins, rand_bits(1));
        end
        report_test("branches");

        for (i = 0; i < 150; i++) begin
            ins = gen_mem(rand_bits(1));
            run_mem(ins, DRSP_DONE);
        end
        report_test("loads and stores");

        for (i = 0; i < 60; i++) begin
            ins = gen_mem(rand_bits(1));
            case (rand_bits(2))
                2'd0:    kind = DRSP_MISALIGNED;
                2'd1:    kind = DRSP_ACCESS_FAULT;
                default: kind = DRSP_PAGE_FAULT;
            endcase
            run_mem(ins, kind);
        end
        for (i = 0; i < 60; i++)
            run_comb(gen_illegal(), 1'b0);
        report_test("exceptions");

        $display("Total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+test
common/exec_pkg.sv
hw/instr_decoder.sv
hw/alu.sv
hw/branch_unit.sv
mem_access/mem_access.sv
hw/exec_control.sv
hw/execute_stage.sv
test/tb_clock.sv
test/execute_stage_tb.sv
